/* design/hdc_pkg.sv */
package hdc_pkg;

    localparam int INSTR_W     = 16;
    localparam int CHUNK_W     = 32;
    localparam int ITEM_ADDR_W = 9;
    localparam int ITEM_DEPTH  = 512;
    localparam int ROT_W       = 8;

    // load form, bit 15 set
    typedef struct packed {
        logic                   is_load;
        logic                   spare_hi;
        logic                   wr_acc;
        logic [3:0]             spare_lo;
        logic [ITEM_ADDR_W-1:0] item_addr;
    } load_fields_t;

    // operation form, bit 15 clear
    typedef struct packed {
        logic             is_load;
        logic             use_perm;
        logic             wr_acc;
        logic             store;
        logic             wr_bind;
        logic [1:0]       spare;
        logic             last;
        logic [ROT_W-1:0] rot_amt;
    } op_fields_t;

    typedef union packed {
        load_fields_t load;
        op_fields_t   op;
    } instr_t;

    // decoded command held for the execute stage
    typedef struct packed {
        logic             valid;
        logic             is_load;
        logic             use_perm;
        logic             wr_acc;
        logic             wr_bind;
        logic             store;
        logic             last;
        logic [ROT_W-1:0] rot_amt;
    } exec_ctrl_t;

    typedef struct packed {
        logic                   en;
        logic [ITEM_ADDR_W-1:0] addr;
    } item_wr_t;

endpackage

/* design/hdc_ctrl.sv */
module hdc_ctrl #(
    parameter int THREADS = 5
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       run,
    input  logic                       instr_valid,
    input  hdc_pkg::instr_t            instr,
    output hdc_pkg::exec_ctrl_t        ex_ctrl,
    output logic [$clog2(THREADS)-1:0] ex_thread
);
    import hdc_pkg::*;

    localparam int TW = $clog2(THREADS);

    exec_ctrl_t    dec;
    logic [TW-1:0] thread_ptr;
    logic [TW-1:0] thread_nxt;

    // same word read through either view of the union
    always_comb begin
        dec = '0;
        if (instr_valid) begin
            dec.valid = 1'b1;
            if (instr.load.is_load) begin
                dec.is_load = 1'b1;
                dec.wr_acc  = instr.load.wr_acc;
            end else begin
                dec.use_perm = instr.op.use_perm;
                dec.wr_acc   = instr.op.wr_acc;
                dec.wr_bind  = instr.op.wr_bind;
                dec.store    = instr.op.store;
                dec.last     = instr.op.last;
                dec.rot_amt  = instr.op.rot_amt;
            end
        end
    end

    // round robin over the threads
    always_comb begin
        if (thread_ptr == TW'(THREADS - 1)) begin
            thread_nxt = '0;
        end else begin
            thread_nxt = thread_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            thread_ptr <= '0;
            ex_ctrl    <= '0;
            ex_thread  <= '0;
        end else if (!run) begin
            // pointer restarts at thread 0 on the next run
            thread_ptr <= '0;
            ex_ctrl    <= '0;
        end else begin
            ex_ctrl <= dec;
            if (instr_valid) begin
                ex_thread  <= thread_ptr;
                thread_ptr <= thread_nxt;
            end
        end
    end

endmodule

/* design/item_loader.sv */
module item_loader #(
    parameter int DIM = 256
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        com,
    input  logic                        chunk_valid,
    input  logic [hdc_pkg::CHUNK_W-1:0] chunk,
    output hdc_pkg::item_wr_t           item_wr,
    output logic [DIM-1:0]              item_data
);
    import hdc_pkg::*;

    localparam int NCHUNK = DIM / CHUNK_W;
    localparam int CNT_W  = (NCHUNK > 1) ? $clog2(NCHUNK) : 1;

    logic [CNT_W-1:0] chunk_cnt;
    logic             last_chunk;

    assign last_chunk = (chunk_cnt == CNT_W'(NCHUNK - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            chunk_cnt <= '0;
            item_wr   <= '0;
        end else if (!com) begin
            chunk_cnt <= '0;
            item_wr   <= '0;
        end else begin
            // one write cycle after the final chunk
            item_wr.en <= chunk_valid && last_chunk;
            if (item_wr.en) begin
                item_wr.addr <= item_wr.addr + 1'b1;
            end
            if (chunk_valid) begin
                if (last_chunk) begin
                    chunk_cnt <= '0;
                end else begin
                    chunk_cnt <= chunk_cnt + 1'b1;
                end
            end
        end
    end

    // first chunk lands in the low bits
    always_ff @(posedge clk) begin
        if (com && chunk_valid) begin
            item_data[chunk_cnt*CHUNK_W +: CHUNK_W] <= chunk;
        end
    end

endmodule

/* design/item_memory.sv */
module item_memory #(
    parameter int DIM = 256
) (
    input  logic                            clk,
    input  hdc_pkg::item_wr_t               item_wr,
    input  logic [DIM-1:0]                  item_data,
    input  logic [hdc_pkg::ITEM_ADDR_W-1:0] rd_addr,
    output logic [DIM-1:0]                  rd_data
);
    import hdc_pkg::*;

    logic [DIM-1:0] mem [ITEM_DEPTH];

    always_ff @(posedge clk) begin
        if (item_wr.en) begin
            mem[item_wr.addr] <= item_data;
        end
    end

    // read before write on a same-address collision
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* design/thread_regfile.sv */
module thread_regfile #(
    parameter int DIM     = 256,
    parameter int THREADS = 5
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [$clog2(THREADS)-1:0] thread,
    input  logic                       acc_we,
    input  logic [DIM-1:0]             acc_wdata,
    input  logic                       bind_we,
    input  logic [DIM-1:0]             bind_wdata,
    output logic [DIM-1:0]             acc_rdata,
    output logic [DIM-1:0]             bind_rdata
);

    logic [DIM-1:0] acc_q  [THREADS];
    logic [DIM-1:0] bind_q [THREADS];

    // only reset clears these, run keeps them
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int t = 0; t < THREADS; t++) begin
                acc_q[t]  <= '0;
                bind_q[t] <= '0;
            end
        end else begin
            if (acc_we) begin
                acc_q[thread] <= acc_wdata;
            end
            if (bind_we) begin
                bind_q[thread] <= bind_wdata;
            end
        end
    end

    // reads see the value before this cycle's write
    assign acc_rdata  = acc_q[thread];
    assign bind_rdata = bind_q[thread];

endmodule

/* design/hv_alu.sv */
module hv_alu #(
    parameter int DIM = 256
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                run,
    input  hdc_pkg::exec_ctrl_t ex_ctrl,
    input  logic [DIM-1:0]      item_rdata,
    input  logic [DIM-1:0]      acc_rdata,
    input  logic [DIM-1:0]      bind_rdata,
    output logic                acc_we,
    output logic [DIM-1:0]      acc_wdata,
    output logic                bind_we,
    output logic [DIM-1:0]      bind_wdata,
    output logic                result_valid,
    output logic [DIM-1:0]      result,
    output logic                last
);
    import hdc_pkg::*;

    logic [ROT_W-1:0] shamt;
    logic [2*DIM-1:0] acc_dbl;
    logic [DIM-1:0]   operand;
    logic [DIM-1:0]   result_q;

    // rotate left, amount taken modulo DIM
    assign shamt   = ROT_W'(ex_ctrl.rot_amt % DIM);
    assign acc_dbl = {acc_rdata, acc_rdata} << shamt;
    assign operand = ex_ctrl.use_perm ? acc_dbl[2*DIM-1 -: DIM] : acc_rdata;

    assign bind_we    = ex_ctrl.valid && ex_ctrl.wr_bind;
    assign bind_wdata = operand;

    // load path or XOR-bind with the old bind value
    assign acc_we    = ex_ctrl.valid && ex_ctrl.wr_acc;
    assign acc_wdata = ex_ctrl.is_load ? item_rdata : (bind_rdata ^ operand);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            last         <= 1'b0;
        end else if (!run) begin
            result_valid <= 1'b0;
            last         <= 1'b0;
        end else begin
            result_valid <= ex_ctrl.valid && ex_ctrl.store;
            // store wins over last
            last         <= ex_ctrl.valid && ex_ctrl.last && !ex_ctrl.store;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_ctrl.valid && ex_ctrl.store) begin
            result_q <= operand;
        end
    end

    assign result = result_valid ? result_q : '0;

endmodule

/* design/hdc_core_top.sv */
module hdc_core_top #(
    parameter int DIM     = 256,
    parameter int THREADS = 5
) (
    input  logic                        clk,
    input  logic                        rst_n,

    // item load side
    input  logic                        com,
    input  logic                        chunk_valid,
    input  logic [hdc_pkg::CHUNK_W-1:0] chunk,

    // instruction side
    input  logic                        run,
    input  logic                        instr_valid,
    input  logic [hdc_pkg::INSTR_W-1:0] instr,

    output logic                        result_valid,
    output logic [DIM-1:0]              result,
    output logic                        last
);
    import hdc_pkg::*;

    localparam int TW = $clog2(THREADS);

    instr_t         instr_u;
    exec_ctrl_t     ex_ctrl;
    logic [TW-1:0]  ex_thread;
    item_wr_t       item_wr;
    logic [DIM-1:0] item_data;
    logic [DIM-1:0] item_rdata;
    logic           acc_we;
    logic [DIM-1:0] acc_wdata;
    logic [DIM-1:0] acc_rdata;
    logic           bind_we;
    logic [DIM-1:0] bind_wdata;
    logic [DIM-1:0] bind_rdata;

    assign instr_u = instr;

    hdc_ctrl #(.THREADS(THREADS)) i_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .instr_valid (instr_valid),
        .instr       (instr_u),
        .ex_ctrl     (ex_ctrl),
        .ex_thread   (ex_thread)
    );

    item_loader #(.DIM(DIM)) i_loader (
        .clk         (clk),
        .rst_n       (rst_n),
        .com         (com),
        .chunk_valid (chunk_valid),
        .chunk       (chunk),
        .item_wr     (item_wr),
        .item_data   (item_data)
    );

    // read address taken straight from the incoming word
    item_memory #(.DIM(DIM)) i_item_mem (
        .clk       (clk),
        .item_wr   (item_wr),
        .item_data (item_data),
        .rd_addr   (instr_u.load.item_addr),
        .rd_data   (item_rdata)
    );

    thread_regfile #(.DIM(DIM), .THREADS(THREADS)) i_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .thread     (ex_thread),
        .acc_we     (acc_we),
        .acc_wdata  (acc_wdata),
        .bind_we    (bind_we),
        .bind_wdata (bind_wdata),
        .acc_rdata  (acc_rdata),
        .bind_rdata (bind_rdata)
    );

    hv_alu #(.DIM(DIM)) i_alu (
        .clk          (clk),
        .rst_n        (rst_n),
        .run          (run),
        .ex_ctrl      (ex_ctrl),
        .item_rdata   (item_rdata),
        .acc_rdata    (acc_rdata),
        .bind_rdata   (bind_rdata),
        .acc_we       (acc_we),
        .acc_wdata    (acc_wdata),
        .bind_we      (bind_we),
        .bind_wdata   (bind_wdata),
        .result_valid (result_valid),
        .result       (result),
        .last         (last)
    );

endmodule

/* tests/hdc_core_asserts.sv */
module hdc_core_asserts #(
    parameter int DIM = 256
) (
    input logic           clk,
    input logic           rst_n,
    input logic           run,
    input logic           result_valid,
    input logic [DIM-1:0] result,
    input logic           last
);

    int n_excl = 0;
    int n_zero = 0;
    int n_run  = 0;

    // store wins, so the two pulses never overlap
    a_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(result_valid && last))
        else begin
            $error("result_valid and last high in the same cycle");
            n_excl++;
        end

    a_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !result_valid |-> result == '0)
        else begin
            $error("result not zero while result_valid is low");
            n_zero++;
        end

    // outputs cleared one edge after run was seen low
    a_run: assert property (@(posedge clk) disable iff (!rst_n)
        !run |=> (!result_valid && !last))
        else begin
            $error("output pulse in the cycle after run was low");
            n_run++;
        end

endmodule

bind hdc_core_top hdc_core_asserts #(.DIM(DIM)) i_asserts (
    .clk          (clk),
    .rst_n        (rst_n),
    .run          (run),
    .result_valid (result_valid),
    .result       (result),
    .last         (last)
);

/* tests/hdc_core_tb.sv */
module hdc_core_tb;
    import hdc_pkg::*;

    localparam int DIM     = 256;
    localparam int THREADS = 5;
    localparam int NCHUNK  = DIM / CHUNK_W;

    // one expected output cycle
    typedef struct packed {
        logic [31:0]    at;
        logic           rv;
        logic           lst;
        logic [DIM-1:0] val;
    } expect_t;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               com;
    logic               chunk_valid;
    logic [CHUNK_W-1:0] chunk;
    logic               run;
    logic               instr_valid;
    logic [INSTR_W-1:0] instr;
    logic               result_valid;
    logic [DIM-1:0]     result;
    logic               last;

    // reference model
    logic [DIM-1:0] item_m [ITEM_DEPTH];
    logic [DIM-1:0] acc_m  [THREADS];
    logic [DIM-1:0] bind_m [THREADS];
    expect_t        exp_q[$];
    int             exp_rd = 0;
    int             cyc = 0;
    int             issued = 0;
    int             seed = 41;
    int             mismatches = 0;
    int             missing = 0;
    int             timeouts = 0;
    int             assert_fails;

    hdc_core_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .com          (com),
        .chunk_valid  (chunk_valid),
        .chunk        (chunk),
        .run          (run),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .result_valid (result_valid),
        .result       (result),
        .last         (last)
    );

    always #4 clk = ~clk;

    function automatic logic [DIM-1:0] rotl(input logic [DIM-1:0] v, input int amt);
        logic [DIM-1:0] r;
        int             s;
        s = amt % DIM;
        for (int i = 0; i < DIM; i++) begin
            r[(i + s) % DIM] = v[i];
        end
        return r;
    endfunction

    function automatic logic [15:0] load_word(input logic [8:0] addr, input logic wr_acc);
        return {1'b1, 1'b0, wr_acc, 4'b0000, addr};
    endfunction

    function automatic logic [15:0] op_word(input logic use_perm, input logic wr_acc,
                                            input logic store, input logic wr_bind,
                                            input logic lst, input logic [7:0] rot);
        return {1'b0, use_perm, wr_acc, store, wr_bind, 2'b00, lst, rot};
    endfunction

    task automatic check_outputs(input expect_t e);
        if (e.rv && result_valid !== 1'b1) begin
            $display("no result_valid pulse at time %0t where a store result was due", $time);
            missing++;
        end else if (result_valid !== e.rv) begin
            $display("MISMATCH time=%0t signal=result_valid expected=%b actual=%b",
                     $time, e.rv, result_valid);
            mismatches++;
        end
        if (e.lst && last !== 1'b1) begin
            $display("no last pulse at time %0t where one was due", $time);
            missing++;
        end else if (last !== e.lst) begin
            $display("MISMATCH time=%0t signal=last expected=%b actual=%b", $time, e.lst, last);
            mismatches++;
        end
        if (result !== e.val) begin
            $display("MISMATCH time=%0t signal=result expected=%h actual=%h",
                     $time, e.val, result);
            mismatches++;
        end
    endtask

    // outputs sampled mid-cycle on every cycle
    always @(negedge clk) begin
        cyc = cyc + 1;
        if (exp_rd < exp_q.size() && exp_q[exp_rd].at == cyc) begin
            check_outputs(exp_q[exp_rd]);
            exp_rd = exp_rd + 1;
        end else begin
            check_outputs('0);
        end
    end

    // drive one instruction and advance the model
    task automatic issue(input logic [15:0] w);
        int             t;
        logic [DIM-1:0] operand;
        logic [DIM-1:0] new_acc;
        expect_t        e;
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= w;
        t = issued % THREADS;
        issued++;
        e = '0;
        // accepted at the next edge and visible one edge later
        e.at = cyc + 3;
        if (w[15]) begin
            if (w[13]) begin
                acc_m[t] = item_m[w[8:0]];
            end
        end else begin
            operand = w[14] ? rotl(acc_m[t], int'(w[7:0])) : acc_m[t];
            new_acc = bind_m[t] ^ operand;
            if (w[11]) begin
                bind_m[t] = operand;
            end
            if (w[13]) begin
                acc_m[t] = new_acc;
            end
            if (w[12]) begin
                e.rv  = 1'b1;
                e.val = operand;
                exp_q.push_back(e);
            end else if (w[8]) begin
                e.lst = 1'b1;
                exp_q.push_back(e);
            end
        end
    endtask

    task automatic end_burst();
        int n;
        @(posedge clk);
        instr_valid <= 1'b0;
        n = 0;
        while (exp_rd < exp_q.size() && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (exp_rd < exp_q.size()) begin
            $display("timeout: %0d expected output pulses never arrived", exp_q.size() - exp_rd);
            timeouts++;
        end
    endtask

    task automatic restart_run(input int low_cycles);
        @(posedge clk);
        run         <= 1'b0;
        instr_valid <= 1'b0;
        repeat (low_cycles) @(posedge clk);
        run <= 1'b1;
        issued = 0;
    endtask

    task automatic load_items(input int count);
        logic [CHUNK_W-1:0] c;
        @(posedge clk);
        com <= 1'b1;
        for (int i = 0; i < count; i++) begin
            for (int j = 0; j < NCHUNK; j++) begin
                c = $random(seed);
                @(posedge clk);
                chunk_valid <= 1'b1;
                chunk       <= c;
                item_m[i][j*CHUNK_W +: CHUNK_W] = c;
            end
        end
        @(posedge clk);
        chunk_valid <= 1'b0;
        // final write lands one edge after the last chunk
        repeat (2) @(posedge clk);
        com <= 1'b0;
    endtask

    task automatic test_idle();
        // stores while run is low must vanish
        for (int k = 0; k < 4; k++) begin
            @(posedge clk);
            instr_valid <= 1'b1;
            instr       <= op_word(1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 8'd0);
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        repeat (3) @(posedge clk);
        run <= 1'b1;
        issued = 0;
        repeat (6) @(posedge clk);
        for (int k = 0; k < THREADS; k++) begin
            issue(op_word(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 8'd0));
        end
        end_burst();
    endtask

    task automatic test_item_load();
        load_items(4);
        for (int k = 0; k < THREADS; k++) begin
            issue(load_word(9'(k % 4), 1'b1));
        end
        for (int k = 0; k < THREADS; k++) begin
            issue(op_word(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 8'd0));
        end
        end_burst();
    endtask

    task automatic test_rotate();
        for (int k = 0; k < THREADS; k++) begin
            issue(op_word(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 8'($random(seed))));
        end
        // accumulators must be untouched
        for (int k = 0; k < THREADS; k++) begin
            issue(op_word(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 8'd0));
        end
        end_burst();
    endtask

    task automatic test_bind();
        for (int k = 0; k < THREADS; k++) begin
            issue(op_word(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 8'($random(seed))));
        end
        for (int k = 0; k < THREADS; k++) begin
            issue(op_word(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 8'($random(seed))));
        end
        for (int k = 0; k < THREADS; k++) begin
            issue(op_word(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 8'd0));
        end
        // bind and acc written together so acc takes the old bind
        for (int k = 0; k < THREADS; k++) begin
            issue(op_word(1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 8'($random(seed))));
        end
        for (int k = 0; k < THREADS; k++) begin
            issue(op_word(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 8'd0));
        end
        end_burst();
    endtask

    task automatic test_threads_run();
        // 12 back to back leaves the pointer at 2
        for (int k = 0; k < 12; k++) begin
            if (k % 3 == 0) begin
                issue(load_word(9'(k % 4), 1'b1));
            end else if (k % 3 == 1) begin
                issue(op_word(1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 8'($random(seed))));
            end else begin
                issue(op_word(1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 8'($random(seed))));
            end
        end
        end_burst();
        // store still in execute when run drops never comes out
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= op_word(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 8'd0);
        restart_run(3);
        for (int k = 0; k < THREADS; k++) begin
            issue(op_word(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 8'd0));
        end
        end_burst();
    endtask

    task automatic test_last();
        issue(op_word(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 8'd3));
        end_burst();
        // store wins over last
        issue(op_word(1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 8'd7));
        issue(op_word(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 8'd0));
        end_burst();
    endtask

    initial begin
        rst_n       <= 1'b0;
        com         <= 1'b0;
        chunk_valid <= 1'b0;
        chunk       <= '0;
        run         <= 1'b0;
        instr_valid <= 1'b0;
        instr       <= '0;
        for (int t = 0; t < THREADS; t++) begin
            acc_m[t]  = '0;
            bind_m[t] = '0;
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        test_idle();
        test_item_load();
        test_rotate();
        test_bind();
        test_threads_run();
        test_last();
        repeat (4) @(posedge clk);
        assert_fails = i_dut.i_asserts.n_excl + i_dut.i_asserts.n_zero + i_dut.i_asserts.n_run;
        $display("errors: %0d mismatches, %0d missing pulses, %0d timeouts, %0d assertion failures",
                 mismatches, missing, timeouts, assert_fails);
        if (mismatches == 0 && missing == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
design/hdc_pkg.sv
design/hdc_ctrl.sv
design/item_loader.sv
design/item_memory.sv
design/thread_regfile.sv
design/hv_alu.sv
design/hdc_core_top.sv
tests/hdc_core_asserts.sv
tests/hdc_core_tb.sv

/* Makefile */
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert -Wall
TOP        ?= hdc_core_tb
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
